/* tb.f */
+incdir+common
common/kq_pkg.sv
keyed_queue_core/kq_hit_stage.sv
keyed_queue_core/kq_entry_array.sv
keyed_queue_core/kq_read_port.sv
src/kq_error_tracker.sv
src/keyed_queue.sv
verification/keyed_queue_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := keyed_queue_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/kq_config.svh
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/keyed_queue_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kq_config.svh"

module keyed_queue_tb;

    localparam int ACC_IDLE = 0;
    localparam int ACC_READ = 1;
    localparam int ACC_WRITE = 2;
    localparam int OP_NONE = 0;
    localparam int OP_INSERT = 1;
    localparam int OP_DELETE = 2;
    localparam int OP_DEQUE = 3;
    localparam int OP_DEQUE_DELETE = 4;
    localparam int RANDOM_CYCLES = 3000;
    localparam int DEQUE_TIMEOUT = 10;

    logic           clk;
    logic           rst;
    kq_pkg::key_t   acc_key;
    kq_pkg::value_t acc_value;
    logic           rd_en;
    logic           wr_en;
    logic           rd_valid;
    logic           rd_hit;
    kq_pkg::value_t rd_value;
    logic           op_en;
    logic           op_id;
    kq_pkg::key_t   op_key;
    kq_pkg::value_t op_value;
    logic           deque_en;
    logic           deque_done;
    kq_pkg::key_t   deque_key;
    kq_pkg::value_t deque_value;
    kq_pkg::error_t error;
    logic           error_fatal;
    logic           full;
    logic           empty;

    int seed = 64163;
    int value_errors = 0;
    int timeout_errors = 0;

    // Reference model with slot 0 at the head
    kq_pkg::key_t   m_key [`KQ_DEPTH];
    kq_pkg::value_t m_val [`KQ_DEPTH];
    int             m_count = 0;
    kq_pkg::error_t exp_err = '0;
    kq_pkg::key_t   next_key = 16'h1000;

    // Expected outputs due two cycles after issue
    logic           exp_rd_valid [$];
    logic           exp_rd_hit [$];
    kq_pkg::value_t exp_rd_value [$];
    logic           exp_dq_done [$];
    kq_pkg::key_t   exp_dq_key [$];
    kq_pkg::value_t exp_dq_value [$];
    kq_pkg::error_t exp_error [$];
    int             exp_count [$];

    keyed_queue keyed_queue_inst (
        .clk(clk), .rst(rst),
        .acc_key(acc_key), .acc_value(acc_value), .rd_en(rd_en), .wr_en(wr_en),
        .rd_valid(rd_valid), .rd_hit(rd_hit), .rd_value(rd_value),
        .op_en(op_en), .op_id(op_id), .op_key(op_key), .op_value(op_value),
        .deque_en(deque_en), .deque_done(deque_done), .deque_key(deque_key),
        .deque_value(deque_value), .error(error), .error_fatal(error_fatal),
        .full(full), .empty(empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int find_slot(input kq_pkg::key_t key);
        for (int i = 0; i < m_count; i++) begin
            if (m_key[i] == key) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Mostly a present key and sometimes one that can never be present
    function automatic kq_pkg::key_t choose_key();
        if (m_count > 0 && pick(10) != 0) begin
            return m_key[pick(m_count)];
        end
        return 16'h8000 | kq_pkg::key_t'(pick(32768));
    endfunction

    task automatic remove_slot(input int idx);
        for (int i = idx; i < m_count - 1; i++) begin
            m_key[i] = m_key[i+1];
            m_val[i] = m_val[i+1];
        end
        m_count--;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        logic           ev;
        logic           eh;
        kq_pkg::value_t eval;
        logic           ed;
        kq_pkg::key_t   ekey;
        kq_pkg::value_t edval;
        kq_pkg::error_t eerr;
        int             ecount;
        ev = exp_rd_valid.pop_front();
        eh = exp_rd_hit.pop_front();
        eval = exp_rd_value.pop_front();
        ed = exp_dq_done.pop_front();
        ekey = exp_dq_key.pop_front();
        edval = exp_dq_value.pop_front();
        eerr = exp_error.pop_front();
        ecount = exp_count.pop_front();
        check_value("rd_valid", rd_valid, ev);
        if (ev) begin
            check_value("rd_hit", rd_hit, eh);
            check_value("rd_value", rd_value, eval);
        end
        check_value("deque_done", deque_done, ed);
        if (ed) begin
            check_value("deque_key", deque_key, ekey);
            check_value("deque_value", deque_value, edval);
        end
        check_value("error", error, eerr);
        check_value("error_fatal", error_fatal, (eerr & `KQ_ERR_FATAL_MASK) != '0);
        check_value("full", full, ecount == `KQ_DEPTH);
        check_value("empty", empty, ecount == 0);
    endtask

    task automatic push_expected(input logic rv, input logic rh, input kq_pkg::value_t rval,
                                 input logic dd, input kq_pkg::key_t dkey,
                                 input kq_pkg::value_t dval);
        exp_rd_valid.push_back(rv);
        exp_rd_hit.push_back(rh);
        exp_rd_value.push_back(rval);
        exp_dq_done.push_back(dd);
        exp_dq_key.push_back(dkey);
        exp_dq_value.push_back(dval);
        exp_error.push_back(exp_err);
        exp_count.push_back(m_count);
    endtask

    // Hold reset for three cycles with idle inputs and restart the model
    task automatic reset_dut();
        rst = 1'b1;
        acc_key = '0;
        acc_value = '0;
        rd_en = 1'b0;
        wr_en = 1'b0;
        op_en = 1'b0;
        op_id = 1'b0;
        op_key = '0;
        op_value = '0;
        deque_en = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        m_count = 0;
        exp_err = '0;
        exp_rd_valid.delete();
        exp_rd_hit.delete();
        exp_rd_value.delete();
        exp_dq_done.delete();
        exp_dq_key.delete();
        exp_dq_value.delete();
        exp_error.delete();
        exp_count.delete();
        // Requests issued during reset are all idle
        push_expected(1'b0, 1'b0, '0, 1'b0, '0, '0);
        push_expected(1'b0, 1'b0, '0, 1'b0, '0, '0);
    endtask

    // Check what is due, update the model and drive the next request
    task automatic step_cycle(input int acc_kind, input kq_pkg::key_t a_key,
                              input kq_pkg::value_t a_val, input int op_kind,
                              input kq_pkg::key_t o_key, input kq_pkg::value_t o_val);
        int             hit;
        int             del;
        logic           rh;
        kq_pkg::value_t rval;
        logic           dd;
        kq_pkg::key_t   dkey;
        kq_pkg::value_t dval;
        @(posedge clk);
        #1;
        check_outputs();
        hit = find_slot(a_key);
        del = find_slot(o_key);
        rh = (acc_kind == ACC_READ) && (hit >= 0);
        rval = rh ? m_val[hit] : '0;
        dd = 1'b0;
        dkey = '0;
        dval = '0;
        if (acc_kind == ACC_WRITE) begin
            if (hit >= 0) begin
                m_val[hit] = a_val;
            end else begin
                exp_err[`KQ_ERR_WRITE_MISS] = 1'b1;
            end
        end
        if (acc_kind != ACC_IDLE && op_kind == OP_DELETE && hit >= 0 && del == hit) begin
            exp_err[`KQ_ERR_ACCESS_DELETE] = 1'b1;
        end
        case (op_kind)
            OP_DELETE: begin
                if (del >= 0) begin
                    remove_slot(del);
                end else begin
                    exp_err[`KQ_ERR_DELETE_MISS] = 1'b1;
                end
            end
            OP_DEQUE, OP_DEQUE_DELETE: begin
                // Head delete plus pop leaves the same entries as a pop
                dd = 1'b1;
                dkey = m_key[0];
                dval = m_val[0];
                remove_slot(0);
                if (op_kind == OP_DEQUE_DELETE) begin
                    exp_err[`KQ_ERR_DEQUE_DELETE] = 1'b1;
                end
            end
            OP_INSERT: begin
                if (m_count < `KQ_DEPTH) begin
                    m_key[m_count] = o_key;
                    m_val[m_count] = o_val;
                    m_count++;
                end else begin
                    exp_err[`KQ_ERR_INSERT_FULL] = 1'b1;
                end
            end
            default: begin
            end
        endcase
        push_expected(acc_kind == ACC_READ, rh, rval, dd, dkey, dval);
        rd_en = (acc_kind == ACC_READ);
        wr_en = (acc_kind == ACC_WRITE);
        acc_key = a_key;
        acc_value = a_val;
        op_en = (op_kind == OP_INSERT) || (op_kind == OP_DELETE) || (op_kind == OP_DEQUE_DELETE);
        op_id = (op_kind == OP_INSERT) ? `KQ_OP_INSERT : `KQ_OP_DELETE;
        op_key = o_key;
        op_value = o_val;
        deque_en = (op_kind == OP_DEQUE) || (op_kind == OP_DEQUE_DELETE);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            step_cycle(ACC_IDLE, '0, '0, OP_NONE, '0, '0);
        end
    endtask

    task automatic insert_new();
        step_cycle(ACC_IDLE, '0, '0, OP_INSERT, next_key, kq_pkg::value_t'($random(seed)));
        next_key++;
    endtask

    task automatic measure_deque_latency();
        int   waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        step_cycle(ACC_IDLE, '0, '0, OP_DEQUE, '0, '0);
        while (!seen && waited < DEQUE_TIMEOUT) begin
            idle_cycles(1);
            waited++;
            seen = deque_done;
        end
        assert (seen) else begin
            timeout_errors++;
            $display("Timeout, deque_done did not rise within %0d cycles", DEQUE_TIMEOUT);
        end
        if (seen) begin
            check_value("deque latency", waited, 2);
        end
    endtask

    initial begin
        int             acc_kind;
        int             op_kind;
        int             r;
        kq_pkg::key_t   a_key;
        kq_pkg::key_t   o_key;
        kq_pkg::value_t o_val;
        reset_dut();
        check_value("empty", empty, 1);
        check_value("full", full, 0);
        check_value("error", error, 0);
        check_value("rd_valid", rd_valid, 0);
        check_value("deque_done", deque_done, 0);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = pick(8);
            acc_kind = (r < 3) ? ACC_IDLE : (r < 6) ? ACC_READ : ACC_WRITE;
            a_key = choose_key();
            r = pick(8);
            op_kind = OP_NONE;
            if (r < 4 && m_count < `KQ_DEPTH) begin
                op_kind = OP_INSERT;
            end else if (r < 5 && m_count > 0) begin
                op_kind = OP_DELETE;
            end else if (r < 7 && m_count > 0) begin
                op_kind = OP_DEQUE;
            end
            o_key = (op_kind == OP_INSERT) ? next_key : choose_key();
            if (op_kind == OP_INSERT) begin
                next_key++;
            end
            o_val = kq_pkg::value_t'($random(seed));
            step_cycle(acc_kind, a_key, kq_pkg::value_t'($random(seed)), op_kind, o_key, o_val);
        end

        for (int i = 0; i < `KQ_DEPTH && m_count > 0; i++) begin
            step_cycle(ACC_IDLE, '0, '0, OP_DEQUE, '0, '0);
        end
        idle_cycles(2);

        // Misses and a delete from the middle
        reset_dut();
        repeat (3) insert_new();
        step_cycle(ACC_READ, 16'h8001, '0, OP_NONE, '0, '0);
        step_cycle(ACC_READ, m_key[1], '0, OP_NONE, '0, '0);
        step_cycle(ACC_WRITE, m_key[1], 16'hbeef, OP_NONE, '0, '0);
        step_cycle(ACC_READ, m_key[1], '0, OP_NONE, '0, '0);
        step_cycle(ACC_WRITE, 16'h8002, 16'h1234, OP_NONE, '0, '0);
        step_cycle(ACC_IDLE, '0, '0, OP_DELETE, 16'h8003, '0);
        step_cycle(ACC_IDLE, '0, '0, OP_DELETE, m_key[1], '0);
        idle_cycles(2);
        check_value("error[write_miss]", error[`KQ_ERR_WRITE_MISS], 1);
        check_value("error[delete_miss]", error[`KQ_ERR_DELETE_MISS], 1);
        check_value("error_fatal", error_fatal, 0);

        for (int i = 0; i < `KQ_DEPTH && m_count < `KQ_DEPTH; i++) begin
            insert_new();
        end
        idle_cycles(2);
        check_value("full", full, 1);
        measure_deque_latency();

        // Insert into a full queue with nothing shifting
        insert_new();
        insert_new();
        idle_cycles(2);
        check_value("error[insert_full]", error[`KQ_ERR_INSERT_FULL], 1);
        check_value("error_fatal", error_fatal, 1);

        // Dequeue and delete of the head in one cycle
        reset_dut();
        repeat (2) insert_new();
        step_cycle(ACC_IDLE, '0, '0, OP_DEQUE_DELETE, m_key[0], '0);
        idle_cycles(2);
        check_value("error[deque_delete]", error[`KQ_ERR_DEQUE_DELETE], 1);
        check_value("error_fatal", error_fatal, 1);

        $display("Error counts: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/keyed_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kq_config.svh"

module keyed_queue (
    input  logic           clk,
    input  logic           rst,
    // Access port, read or value rewrite by key
    input  kq_pkg::key_t   acc_key,
    input  kq_pkg::value_t acc_value,
    input  logic           rd_en,
    input  logic           wr_en,
    output logic           rd_valid,
    output logic           rd_hit,
    output kq_pkg::value_t rd_value,
    // Insert or delete
    input  logic           op_en,
    input  logic           op_id,
    input  kq_pkg::key_t   op_key,
    input  kq_pkg::value_t op_value,
    // Head pop
    input  logic           deque_en,
    output logic           deque_done,
    output kq_pkg::key_t   deque_key,
    output kq_pkg::value_t deque_value,
    // Status
    output kq_pkg::error_t error,
    output logic           error_fatal,
    output logic           full,
    output logic           empty
);

    // Stage 0 registers
    logic acc_rd_r, acc_wr_r, op_insert_r, op_delete_r, deque_r;
    kq_pkg::value_t acc_value_r;
    kq_pkg::key_t   op_key_r;
    kq_pkg::value_t op_value_r;
    kq_pkg::slot_vec_t acc_hit_r;
    kq_pkg::slot_vec_t del_hit_r;

    // Entry storage and occupancy
    kq_pkg::key_t   [`KQ_DEPTH-1:0] entry_key;
    kq_pkg::value_t [`KQ_DEPTH-1:0] entry_value;
    kq_pkg::slot_vec_t valid_vec;
    kq_pkg::slot_vec_t shift_vec;
    kq_pkg::slot_vec_t first_empty;

    // Error strobes
    logic corrupt, insert_full, dup_hit;
    logic deque_delete, delete_miss, write_miss, access_delete;

    kq_hit_stage kq_hit_stage_inst (
        .clk(clk), .rst(rst),
        .acc_key(acc_key), .acc_value(acc_value), .rd_en(rd_en), .wr_en(wr_en),
        .op_en(op_en), .op_id(op_id), .op_key(op_key), .op_value(op_value),
        .deque_en(deque_en), .entry_key(entry_key), .valid_vec(valid_vec),
        .shift_vec(shift_vec), .first_empty(first_empty),
        .acc_rd_r(acc_rd_r), .acc_wr_r(acc_wr_r), .acc_value_r(acc_value_r),
        .op_insert_r(op_insert_r), .op_delete_r(op_delete_r), .op_key_r(op_key_r),
        .op_value_r(op_value_r), .deque_r(deque_r),
        .acc_hit_r(acc_hit_r), .del_hit_r(del_hit_r),
        .deque_delete(deque_delete), .delete_miss(delete_miss),
        .write_miss(write_miss), .access_delete(access_delete)
    );

    kq_entry_array kq_entry_array_inst (
        .clk(clk), .rst(rst),
        .acc_wr_r(acc_wr_r), .acc_value_r(acc_value_r), .acc_hit_r(acc_hit_r),
        .op_insert_r(op_insert_r), .op_key_r(op_key_r), .op_value_r(op_value_r),
        .del_hit_r(del_hit_r), .deque_r(deque_r),
        .entry_key(entry_key), .entry_value(entry_value), .valid_vec(valid_vec),
        .shift_vec(shift_vec), .first_empty(first_empty),
        .full(full), .empty(empty), .corrupt(corrupt), .insert_full(insert_full)
    );

    kq_read_port kq_read_port_inst (
        .clk(clk), .rst(rst),
        .acc_rd_r(acc_rd_r), .acc_wr_r(acc_wr_r), .acc_value_r(acc_value_r),
        .acc_hit_r(acc_hit_r), .deque_r(deque_r),
        .entry_key(entry_key), .entry_value(entry_value),
        .rd_valid(rd_valid), .rd_hit(rd_hit), .rd_value(rd_value),
        .deque_done(deque_done), .deque_key(deque_key), .deque_value(deque_value),
        .dup_hit(dup_hit)
    );

    kq_error_tracker kq_error_tracker_inst (
        .clk(clk), .rst(rst),
        .insert_full(insert_full), .dup_hit(dup_hit), .corrupt(corrupt),
        .deque_delete(deque_delete), .delete_miss(delete_miss),
        .write_miss(write_miss), .access_delete(access_delete),
        .error(error), .error_fatal(error_fatal)
    );

endmodule

`default_nettype wire

/* src/kq_error_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kq_config.svh"

module kq_error_tracker (
    input  logic           clk,
    input  logic           rst,
    input  logic           insert_full,
    input  logic           dup_hit,
    input  logic           corrupt,
    input  logic           deque_delete,
    input  logic           delete_miss,
    input  logic           write_miss,
    input  logic           access_delete,
    output kq_pkg::error_t error,
    output logic           error_fatal
);

    kq_pkg::error_t event_vec;

    // Map each strobe onto its bit
    always_comb begin
        event_vec = '0;
        event_vec[`KQ_ERR_INSERT_FULL]   = insert_full;
        event_vec[`KQ_ERR_DUPLICATES]    = dup_hit;
        event_vec[`KQ_ERR_CORRUPT]       = corrupt;
        event_vec[`KQ_ERR_DEQUE_DELETE]  = deque_delete;
        event_vec[`KQ_ERR_DELETE_MISS]   = delete_miss;
        event_vec[`KQ_ERR_WRITE_MISS]    = write_miss;
        event_vec[`KQ_ERR_ACCESS_DELETE] = access_delete;
    end

    // Bits stay set until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= '0;
        end else begin
            error <= error | event_vec;
        end
    end

    assign error_fatal = (error & `KQ_ERR_FATAL_MASK) != '0;

endmodule

`default_nettype wire

/* keyed_queue_core/kq_read_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kq_config.svh"

module kq_read_port (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             acc_rd_r,
    input  logic                             acc_wr_r,
    input  kq_pkg::value_t                   acc_value_r,
    input  kq_pkg::slot_vec_t                acc_hit_r,
    input  logic                             deque_r,
    input  kq_pkg::key_t   [`KQ_DEPTH-1:0]   entry_key,
    input  kq_pkg::value_t [`KQ_DEPTH-1:0]   entry_value,
    output logic                             rd_valid,
    output logic                             rd_hit,
    output kq_pkg::value_t                   rd_value,
    output logic                             deque_done,
    output kq_pkg::key_t                     deque_key,
    output kq_pkg::value_t                   deque_value,
    output logic                             dup_hit
);

    kq_pkg::value_t sel_value;
    kq_pkg::value_t head_value;

    // AND-OR select, zero when nothing hits
    always_comb begin
        sel_value = '0;
        for (int i = 0; i < `KQ_DEPTH; i++) begin
            if (acc_hit_r[i]) begin
                sel_value = sel_value | entry_value[i];
            end
        end
    end

    // More than one bit set means two entries share a key
    assign dup_hit = (acc_hit_r & (acc_hit_r - 1'b1)) != '0;

    // Same-cycle write to the head goes straight to the dequeue output
    assign head_value = (acc_wr_r & acc_hit_r[0]) ? acc_value_r : entry_value[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid   <= 1'b0;
            rd_hit     <= 1'b0;
            deque_done <= 1'b0;
        end else begin
            rd_valid   <= acc_rd_r;
            rd_hit     <= acc_rd_r & (acc_hit_r != '0);
            deque_done <= deque_r;
        end
    end

    always_ff @(posedge clk) begin
        rd_value    <= sel_value;
        deque_key   <= entry_key[0];
        deque_value <= head_value;
    end

endmodule

`default_nettype wire

/* keyed_queue_core/kq_entry_array.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kq_config.svh"

module kq_entry_array (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             acc_wr_r,
    input  kq_pkg::value_t                   acc_value_r,
    input  kq_pkg::slot_vec_t                acc_hit_r,
    input  logic                             op_insert_r,
    input  kq_pkg::key_t                     op_key_r,
    input  kq_pkg::value_t                   op_value_r,
    input  kq_pkg::slot_vec_t                del_hit_r,
    input  logic                             deque_r,
    output kq_pkg::key_t   [`KQ_DEPTH-1:0]   entry_key,
    output kq_pkg::value_t [`KQ_DEPTH-1:0]   entry_value,
    output kq_pkg::slot_vec_t                valid_vec,
    output kq_pkg::slot_vec_t                shift_vec,
    output kq_pkg::slot_vec_t                first_empty,
    output logic                             full,
    output logic                             empty,
    output logic                             corrupt,
    output logic                             insert_full
);

    kq_pkg::count_t                  count;
    kq_pkg::key_t   [`KQ_DEPTH-1:0]  nb_key;
    kq_pkg::value_t [`KQ_DEPTH-1:0]  nb_value;
    kq_pkg::slot_vec_t               nb_valid;
    kq_pkg::slot_vec_t               nb_hit;
    kq_pkg::slot_vec_t               nb_first;
    kq_pkg::slot_vec_t               wr_here;
    kq_pkg::slot_vec_t               ins_here;
    kq_pkg::key_t   [`KQ_DEPTH-1:0]  key_nxt;
    kq_pkg::value_t [`KQ_DEPTH-1:0]  value_nxt;
    kq_pkg::slot_vec_t               valid_nxt;

    // Shift cascades from the dequeue or the deleted slot to the tail
    always_comb begin
        shift_vec[0] = deque_r | del_hit_r[0];
        for (int i = 1; i < `KQ_DEPTH; i++) begin
            shift_vec[i] = shift_vec[i-1] | del_hit_r[i];
        end
    end

    // Valid entries must form one run from slot 0
    always_comb begin
        corrupt = 1'b1;
        count   = '0;
        for (int k = 0; k <= `KQ_DEPTH; k++) begin
            if (valid_vec == kq_pkg::slot_vec_t'((1 << k) - 1)) begin
                corrupt = 1'b0;
                count   = kq_pkg::count_t'(k);
            end
        end
    end

    // Insert slot follows the last valid entry
    assign first_empty = ~valid_vec & {valid_vec[`KQ_DEPTH-2:0], 1'b1};

    assign full        = (count == kq_pkg::count_t'(`KQ_DEPTH));
    assign empty       = (valid_vec == '0);
    assign insert_full = op_insert_r & full & !shift_vec[`KQ_DEPTH-1];

    // Neighbour view; the tail pulls in a cleared slot
    assign nb_key   = {kq_pkg::key_t'(0), entry_key[`KQ_DEPTH-1:1]};
    assign nb_value = {kq_pkg::value_t'(0), entry_value[`KQ_DEPTH-1:1]};
    assign nb_valid = {1'b0, valid_vec[`KQ_DEPTH-1:1]};
    assign nb_hit   = {1'b0, acc_hit_r[`KQ_DEPTH-1:1]};
    assign nb_first = {first_empty == '0, first_empty[`KQ_DEPTH-1:1]};

    // Writes and inserts follow their slot when it moves
    assign wr_here  = (shift_vec & nb_hit) | (~shift_vec & acc_hit_r);
    assign ins_here = (shift_vec & nb_first) | (~shift_vec & first_empty);

    always_comb begin
        for (int i = 0; i < `KQ_DEPTH; i++) begin
            key_nxt[i]   = shift_vec[i] ? nb_key[i] : entry_key[i];
            value_nxt[i] = shift_vec[i] ? nb_value[i] : entry_value[i];
            valid_nxt[i] = shift_vec[i] ? nb_valid[i] : valid_vec[i];
            if (acc_wr_r && wr_here[i]) begin
                value_nxt[i] = acc_value_r;
            end else if (op_insert_r && ins_here[i]) begin
                key_nxt[i]   = op_key_r;
                value_nxt[i] = op_value_r;
                valid_nxt[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_vec <= '0;
        end else begin
            valid_vec <= valid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        entry_key   <= key_nxt;
        entry_value <= value_nxt;
    end

    // Insert position is unique
    assert property (@(posedge clk) disable iff (rst) $onehot0(first_empty));

endmodule

`default_nettype wire

/* keyed_queue_core/kq_hit_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kq_config.svh"

module kq_hit_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  kq_pkg::key_t                   acc_key,
    input  kq_pkg::value_t                 acc_value,
    input  logic                           rd_en,
    input  logic                           wr_en,
    input  logic                           op_en,
    input  logic                           op_id,
    input  kq_pkg::key_t                   op_key,
    input  kq_pkg::value_t                 op_value,
    input  logic                           deque_en,
    input  kq_pkg::key_t [`KQ_DEPTH-1:0]   entry_key,
    input  kq_pkg::slot_vec_t              valid_vec,
    input  kq_pkg::slot_vec_t              shift_vec,
    input  kq_pkg::slot_vec_t              first_empty,
    output logic                           acc_rd_r,
    output logic                           acc_wr_r,
    output kq_pkg::value_t                 acc_value_r,
    output logic                           op_insert_r,
    output logic                           op_delete_r,
    output kq_pkg::key_t                   op_key_r,
    output kq_pkg::value_t                 op_value_r,
    output logic                           deque_r,
    output kq_pkg::slot_vec_t              acc_hit_r,
    output kq_pkg::slot_vec_t              del_hit_r,
    output logic                           deque_delete,
    output logic                           delete_miss,
    output logic                           write_miss,
    output logic                           access_delete
);

    logic                          acc_en;
    logic                          del_en;
    kq_pkg::key_t [`KQ_DEPTH-1:0]  nb_key;
    kq_pkg::slot_vec_t             nb_valid;
    kq_pkg::slot_vec_t             nb_first;
    kq_pkg::key_t [`KQ_DEPTH-1:0]  src_key;
    kq_pkg::slot_vec_t             src_valid;
    kq_pkg::slot_vec_t             src_insert;
    kq_pkg::slot_vec_t             acc_hit_nxt;
    kq_pkg::slot_vec_t             del_hit_nxt;

    assign acc_en = rd_en | wr_en;
    assign del_en = op_en & (op_id == `KQ_OP_DELETE);

    // Right-hand neighbour of each slot; the tail sees an empty slot
    assign nb_key   = {kq_pkg::key_t'(0), entry_key[`KQ_DEPTH-1:1]};
    assign nb_valid = {1'b0, valid_vec[`KQ_DEPTH-1:1]};
    // A full queue that shifts takes the insert in its last slot
    assign nb_first = {first_empty == '0, first_empty[`KQ_DEPTH-1:1]};

    // Compare against the slot contents as they will be after the
    // update now in stage 1, so the next stage sees a consistent view
    always_comb begin
        for (int i = 0; i < `KQ_DEPTH; i++) begin
            src_key[i]    = shift_vec[i] ? nb_key[i] : entry_key[i];
            src_valid[i]  = shift_vec[i] ? nb_valid[i] : valid_vec[i];
            src_insert[i] = op_insert_r & (shift_vec[i] ? nb_first[i] : first_empty[i]);
            acc_hit_nxt[i] = acc_en & ((src_valid[i] & (acc_key == src_key[i])) |
                                       (src_insert[i] & (acc_key == op_key_r)));
            del_hit_nxt[i] = del_en & ((src_valid[i] & (op_key == src_key[i])) |
                                       (src_insert[i] & (op_key == op_key_r)));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_rd_r    <= 1'b0;
            acc_wr_r    <= 1'b0;
            op_insert_r <= 1'b0;
            op_delete_r <= 1'b0;
            deque_r     <= 1'b0;
            acc_hit_r   <= '0;
            del_hit_r   <= '0;
        end else begin
            acc_rd_r    <= rd_en;
            acc_wr_r    <= wr_en;
            op_insert_r <= op_en & (op_id == `KQ_OP_INSERT);
            op_delete_r <= del_en;
            deque_r     <= deque_en;
            acc_hit_r   <= acc_hit_nxt;
            del_hit_r   <= del_hit_nxt;
        end
    end

    always_ff @(posedge clk) begin
        acc_value_r <= acc_value;
        op_key_r    <= op_key;
        op_value_r  <= op_value;
    end

    // Request-level conflicts, seen in stage 1
    assign deque_delete  = deque_r & op_delete_r;
    assign delete_miss   = op_delete_r & (del_hit_r == '0);
    assign write_miss    = acc_wr_r & (acc_hit_r == '0);
    assign access_delete = (acc_rd_r | acc_wr_r) & ((acc_hit_r & del_hit_r) != '0);

    // Only one access kind per cycle
    assert property (@(posedge clk) disable iff (rst) !(rd_en && wr_en));

    // Patched hits never name two slots
    assert property (@(posedge clk) disable iff (rst) $onehot0(acc_hit_r));

endmodule

`default_nettype wire

/* common/kq_pkg.sv */
`default_nettype none

`include "kq_config.svh"

package kq_pkg;

    // Flow key used for every lookup
    typedef logic [`KQ_KEY_WIDTH-1:0] key_t;

    // Per-flow state stored with the key
    typedef logic [`KQ_VALUE_WIDTH-1:0] value_t;

    // One bit per entry (hit, valid, shift, first empty)
    typedef logic [`KQ_DEPTH-1:0] slot_vec_t;

    // Valid entry count, 0 up to and including the depth
    typedef logic [`KQ_AWIDTH:0] count_t;

    // Sticky error register
    typedef logic [`KQ_ERROR_WIDTH-1:0] error_t;

endpackage

`default_nettype wire

/* common/kq_config.svh */
`ifndef KQ_CONFIG_SVH
`define KQ_CONFIG_SVH

// Queue geometry
`define KQ_DEPTH        8
`define KQ_AWIDTH       3
`define KQ_KEY_WIDTH    16
`define KQ_VALUE_WIDTH  16

// Sticky error register layout
`define KQ_ERROR_WIDTH        7
`define KQ_ERR_INSERT_FULL    0
`define KQ_ERR_DUPLICATES     1
`define KQ_ERR_CORRUPT        2
`define KQ_ERR_DEQUE_DELETE   3
`define KQ_ERR_DELETE_MISS    4
`define KQ_ERR_WRITE_MISS     5
`define KQ_ERR_ACCESS_DELETE  6
// Bits 0 to 3 leave the queue in an undefined state
`define KQ_ERR_FATAL_MASK     7'b0001111

// Operation codes on op_id
`define KQ_OP_INSERT  1'b0
`define KQ_OP_DELETE  1'b1

`endif
